/* source/offload_pkg.sv */
/*
 * Shared widths, target indices and configuration opcodes for the offload path,
 * plus the request/response structs and the configuration FSM states
 */
`default_nettype none

package offload_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int unsigned ID_W     = 5;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned TARGET_W = 2;

  // ----------------------------------------------------------
  // Targets
  // ----------------------------------------------------------
  // 0 FPU, 1 shared muldiv, 2 DMA, 3 local config
  localparam int unsigned NUM_TARGETS = 4;
  localparam int unsigned TARGET_CFG  = 3;

  // Configuration register space
  localparam int unsigned NUM_DM    = 2;
  localparam int unsigned NUM_REG   = 8;
  localparam int unsigned CFG_IDX_W = 4;

  // Opcodes matched against op[6:0]
  localparam logic [6:0] CFG_OP_READ_IMM  = 7'b0001011;
  localparam logic [6:0] CFG_OP_WRITE_IMM = 7'b0101011;
  localparam logic [6:0] CFG_OP_READ      = 7'b1011011;
  localparam logic [6:0] CFG_OP_WRITE     = 7'b1111011;

  // ----------------------------------------------------------
  // Payloads
  // ----------------------------------------------------------
  typedef struct packed {
    logic [TARGET_W-1:0] target;
    logic [ID_W-1:0]     id;
    logic [31:0]         op;
    logic [DATA_W-1:0]   arga;
    logic [DATA_W-1:0]   argb;
  } acc_req_t;

  // id of zero means no register write-back in the core
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic              error;
    logic [DATA_W-1:0] data;
  } acc_rsp_t;

  typedef enum logic {
    IDLE,
    RESP
  } cfg_state_e;

endpackage

`default_nettype wire

/* source/offload_spill.sv */
/*
 * Two-entry spill register for a valid/ready stream of any payload type
 */
`timescale 1ns/10ps
`default_nettype none

module offload_spill #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  // Entry A takes input, entry B catches A when the output stalls
  logic     a_full_q;
  logic     b_full_q;
  payload_t a_data_q;
  payload_t b_data_q;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  assign a_fill  = in_valid_i && in_ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !out_ready_i;
  assign b_drain = b_full_q && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= in_data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B is always older than A
  assign in_ready_o  = !a_full_q || !b_full_q;
  assign out_valid_o = a_full_q || b_full_q;
  assign out_data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

`default_nettype wire

/* source/offload_router.sv */
/*
 * Request demux by target field and round-robin response arbiter
 */
`timescale 1ns/10ps
`default_nettype none

module offload_router (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  offload_pkg::acc_req_t                           req_i,
  input  logic                                            req_valid_i,
  output logic                                            req_ready_o,
  output logic [offload_pkg::NUM_TARGETS-1:0]             tgt_valid_o,
  input  logic [offload_pkg::NUM_TARGETS-1:0]             tgt_ready_i,
  input  offload_pkg::acc_rsp_t [offload_pkg::NUM_TARGETS-1:0] tgt_rsp_i,
  input  logic [offload_pkg::NUM_TARGETS-1:0]             tgt_rsp_valid_i,
  output logic [offload_pkg::NUM_TARGETS-1:0]             tgt_rsp_ready_o,
  output offload_pkg::acc_rsp_t                           rsp_o,
  output logic                                            rsp_valid_o,
  input  logic                                            rsp_ready_i
);

  // ----------------------------------------------------------
  // Request demux
  // ----------------------------------------------------------
  always_comb begin
    tgt_valid_o = '0;
    tgt_valid_o[req_i.target] = req_valid_i;
  end

  assign req_ready_o = tgt_ready_i[req_i.target];

  // ----------------------------------------------------------
  // Response arbiter
  // ----------------------------------------------------------
  logic [offload_pkg::TARGET_W-1:0] rr_q;
  logic [offload_pkg::TARGET_W-1:0] gnt_idx;
  logic                             gnt_found;

  // First valid input at or after the pointer
  always_comb begin
    logic [offload_pkg::TARGET_W-1:0] cand;
    gnt_found = 1'b0;
    gnt_idx   = rr_q;
    cand      = rr_q;
    for (int off = 0; off < offload_pkg::NUM_TARGETS; off++) begin
      cand = rr_q + off[offload_pkg::TARGET_W-1:0];
      if (!gnt_found && tgt_rsp_valid_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  assign rsp_valid_o = gnt_found;
  assign rsp_o       = tgt_rsp_i[gnt_idx];

  always_comb begin
    tgt_rsp_ready_o = '0;
    tgt_rsp_ready_o[gnt_idx] = gnt_found && rsp_ready_i;
  end

  // Winner gets lowest priority next time
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rr_q <= '0;
    end else if (gnt_found && rsp_ready_i) begin
      rr_q <= gnt_idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/cfg_regfile.sv */
/*
 * Configuration register file, combinational read, clocked write
 */
`timescale 1ns/10ps
`default_nettype none

module cfg_regfile (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [offload_pkg::CFG_IDX_W-1:0] idx_i,
  input  logic                              we_i,
  input  logic [offload_pkg::DATA_W-1:0]    wdata_i,
  output logic [offload_pkg::DATA_W-1:0]    rdata_o
);

  // One row per data-mover register
  logic [offload_pkg::DATA_W-1:0] regs_q [offload_pkg::NUM_DM * offload_pkg::NUM_REG];

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      for (int i = 0; i < offload_pkg::NUM_DM * offload_pkg::NUM_REG; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[idx_i] <= wdata_i;
    end
  end

  // Read sees the value from before a same-cycle write
  assign rdata_o = regs_q[idx_i];

endmodule

`default_nettype wire

/* source/cfg_ctrl.sv */
/*
 * Configuration target: opcode decode, word index, register access
 * and an IDLE/RESP FSM that holds each response until accepted
 */
`timescale 1ns/10ps
`default_nettype none

module cfg_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  offload_pkg::acc_req_t req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output offload_pkg::acc_rsp_t rsp_o,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i
);

  offload_pkg::cfg_state_e           state_q;
  offload_pkg::cfg_state_e           state_d;
  offload_pkg::acc_rsp_t             rsp_q;
  offload_pkg::acc_rsp_t             rsp_d;
  logic [11:0]                       addr;
  logic [4:0]                        addr_dm;
  logic [6:0]                        addr_reg;
  logic [31:0]                       flat_idx;
  logic [offload_pkg::CFG_IDX_W-1:0] rf_idx;
  logic [offload_pkg::DATA_W-1:0]    rf_rdata;
  logic                              is_write;
  logic                              word_valid;
  logic                              req_hs;

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------
  always_comb begin
    addr     = '0;
    is_write = 1'b0;
    case (req_i.op[6:0])
      offload_pkg::CFG_OP_READ_IMM: addr = req_i.op[31:20];
      offload_pkg::CFG_OP_WRITE_IMM: begin
        addr     = req_i.op[31:20];
        is_write = 1'b1;
      end
      offload_pkg::CFG_OP_READ: addr = req_i.argb[11:0];
      offload_pkg::CFG_OP_WRITE: begin
        addr     = req_i.argb[11:0];
        is_write = 1'b1;
      end
      // Unknown opcode reads address 0
      default: ;
    endcase
  end

  // Address halves swap into data mover and register
  assign addr_dm    = addr[4:0];
  assign addr_reg   = addr[11:5];
  assign word_valid = (32'(addr_dm) < offload_pkg::NUM_DM) &&
                      (32'(addr_reg) < offload_pkg::NUM_REG);
  assign flat_idx   = 32'(addr_dm) * offload_pkg::NUM_REG + 32'(addr_reg);
  assign rf_idx     = flat_idx[offload_pkg::CFG_IDX_W-1:0];

  assign req_ready_o = (state_q == offload_pkg::IDLE);
  assign req_hs      = req_valid_i && req_ready_o;

  cfg_regfile i_cfg_regfile (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .idx_i   (rf_idx),
    .we_i    (req_hs && is_write && word_valid),
    .wdata_i (req_i.arga),
    .rdata_o (rf_rdata)
  );

  // Old register value, id 0 on writes so nothing is written back
  always_comb begin
    rsp_d.id    = is_write ? '0 : req_i.id;
    rsp_d.error = 1'b0;
    rsp_d.data  = word_valid ? rf_rdata : '0;
  end

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      offload_pkg::IDLE: if (req_hs) state_d = offload_pkg::RESP;
      offload_pkg::RESP: if (rsp_ready_i) state_d = offload_pkg::IDLE;
      default: state_d = offload_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      state_q <= offload_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = (state_q == offload_pkg::RESP);
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

/* source/core_offload_complex.sv */
/*
 * Offload path top: request cut, router, config target, response cut
 */
`timescale 1ns/10ps
`default_nettype none

module core_offload_complex (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  offload_pkg::acc_req_t                                core_req_i,
  input  logic                                                 core_req_valid_i,
  output logic                                                 core_req_ready_o,
  output offload_pkg::acc_rsp_t                                core_rsp_o,
  output logic                                                 core_rsp_valid_o,
  input  logic                                                 core_rsp_ready_i,
  output offload_pkg::acc_req_t                                ext_req_o,
  output logic [offload_pkg::NUM_TARGETS-2:0]                  ext_req_valid_o,
  input  logic [offload_pkg::NUM_TARGETS-2:0]                  ext_req_ready_i,
  input  offload_pkg::acc_rsp_t [offload_pkg::NUM_TARGETS-2:0] ext_rsp_i,
  input  logic [offload_pkg::NUM_TARGETS-2:0]                  ext_rsp_valid_i,
  output logic [offload_pkg::NUM_TARGETS-2:0]                  ext_rsp_ready_o
);

  localparam int unsigned CFG = offload_pkg::TARGET_CFG;

  offload_pkg::acc_req_t                                req_cut;
  logic                                                 req_cut_valid;
  logic                                                 req_cut_ready;
  logic [offload_pkg::NUM_TARGETS-1:0]                  tgt_valid;
  logic [offload_pkg::NUM_TARGETS-1:0]                  tgt_ready;
  offload_pkg::acc_rsp_t [offload_pkg::NUM_TARGETS-1:0] tgt_rsp;
  logic [offload_pkg::NUM_TARGETS-1:0]                  tgt_rsp_valid;
  logic [offload_pkg::NUM_TARGETS-1:0]                  tgt_rsp_ready;
  offload_pkg::acc_rsp_t                                rsp_arb;
  logic                                                 rsp_arb_valid;
  logic                                                 rsp_arb_ready;

  // External targets sit below the config index
  assign ext_req_o          = req_cut;
  assign ext_req_valid_o    = tgt_valid[CFG-1:0];
  assign tgt_ready[CFG-1:0] = ext_req_ready_i;
  assign tgt_rsp[CFG-1:0]   = ext_rsp_i;
  assign tgt_rsp_valid[CFG-1:0] = ext_rsp_valid_i;
  assign ext_rsp_ready_o    = tgt_rsp_ready[CFG-1:0];

  // Cut on the request path
  offload_spill #(
    .payload_t (offload_pkg::acc_req_t)
  ) i_req_spill (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (core_req_valid_i),
    .in_ready_o  (core_req_ready_o),
    .in_data_i   (core_req_i),
    .out_valid_o (req_cut_valid),
    .out_ready_i (req_cut_ready),
    .out_data_o  (req_cut)
  );

  offload_router i_router (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_cut),
    .req_valid_i     (req_cut_valid),
    .req_ready_o     (req_cut_ready),
    .tgt_valid_o     (tgt_valid),
    .tgt_ready_i     (tgt_ready),
    .tgt_rsp_i       (tgt_rsp),
    .tgt_rsp_valid_i (tgt_rsp_valid),
    .tgt_rsp_ready_o (tgt_rsp_ready),
    .rsp_o           (rsp_arb),
    .rsp_valid_o     (rsp_arb_valid),
    .rsp_ready_i     (rsp_arb_ready)
  );

  cfg_ctrl i_cfg_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_cut),
    .req_valid_i (tgt_valid[CFG]),
    .req_ready_o (tgt_ready[CFG]),
    .rsp_o       (tgt_rsp[CFG]),
    .rsp_valid_o (tgt_rsp_valid[CFG]),
    .rsp_ready_i (tgt_rsp_ready[CFG])
  );

  // Cut on the response path
  offload_spill #(
    .payload_t (offload_pkg::acc_rsp_t)
  ) i_rsp_spill (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (rsp_arb_valid),
    .in_ready_o  (rsp_arb_ready),
    .in_data_i   (rsp_arb),
    .out_valid_o (core_rsp_valid_o),
    .out_ready_i (core_rsp_ready_i),
    .out_data_o  (core_rsp_o)
  );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
/*
 * Free-running testbench clock, 4 ns period
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk_o
);

  localparam int unsigned HALF_PERIOD = 2;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

/* tb/offload_assertions.sv */
/*
 * Handshake stability checks on the core response and the external
 * request ports, bound into the offload top level
 */
`timescale 1ns/10ps
`default_nettype none

module offload_assertions (
  input logic                  clk_i,
  input logic                  rst_ni,
  input offload_pkg::acc_rsp_t rsp_i,
  input logic                  rsp_valid_i,
  input logic                  rsp_ready_i,
  input offload_pkg::acc_req_t ext_req_i,
  input logic [2:0]            ext_valid_i,
  input logic [2:0]            ext_ready_i
);

  // Core response holds until taken
  core_rsp_hold: assert property (@(posedge clk_i) disable iff (rst_ni)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else $error("core_rsp_o dropped valid or changed payload before ready");

  // Each external port holds its request until taken
  for (genvar t = 0; t < 3; t++) begin : g_ext
    ext_req_hold: assert property (@(posedge clk_i) disable iff (rst_ni)
      ext_valid_i[t] && !ext_ready_i[t] |=> ext_valid_i[t] && $stable(ext_req_i))
      else $error("ext_req_o port %0d dropped valid or changed payload before ready", t);
  end

endmodule

bind core_offload_complex offload_assertions i_offload_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .rsp_i       (core_rsp_o),
  .rsp_valid_i (core_rsp_valid_o),
  .rsp_ready_i (core_rsp_ready_i),
  .ext_req_i   (ext_req_o),
  .ext_valid_i (ext_req_valid_o),
  .ext_ready_i (ext_req_ready_i)
);

`default_nettype wire

/* tb/offload_tb.sv */
/*
 * Testbench for the offload complex: random requests, external accelerator
 * models, a configuration register model and response checks
 */
`timescale 1ns/10ps
`default_nettype none

module offload_tb;

  localparam int unsigned NUM_REQ   = 400;
  localparam int unsigned TIMEOUT   = NUM_REQ * 40;
  localparam int unsigned NUM_EXT   = offload_pkg::NUM_TARGETS - 1;
  localparam int unsigned MAX_DELAY = 8;
  localparam int unsigned NUM_WORDS = offload_pkg::NUM_DM * offload_pkg::NUM_REG;

  // Expected configuration response in request order
  typedef struct packed {
    logic                           wr;
    logic [offload_pkg::ID_W-1:0]   id;
    logic [offload_pkg::DATA_W-1:0] data;
  } cfg_exp_t;

  // Pending answer of an external accelerator
  typedef struct packed {
    logic [1:0]            tgt;
    logic [31:0]           due;
    offload_pkg::acc_rsp_t rsp;
  } ext_job_t;

  logic                                  clk;
  logic                                  rst_n;
  offload_pkg::acc_req_t                 core_req;
  logic                                  core_req_valid;
  logic                                  core_req_ready;
  offload_pkg::acc_rsp_t                 core_rsp;
  logic                                  core_rsp_valid;
  logic                                  core_rsp_ready;
  offload_pkg::acc_req_t                 ext_req;
  logic [NUM_EXT-1:0]                    ext_req_valid;
  logic [NUM_EXT-1:0]                    ext_req_ready;
  offload_pkg::acc_rsp_t [NUM_EXT-1:0]   ext_rsp;
  logic [NUM_EXT-1:0]                    ext_rsp_valid;
  logic [NUM_EXT-1:0]                    ext_rsp_ready;

  // Reference model state
  logic [offload_pkg::DATA_W-1:0] cfg_model [NUM_WORDS];
  logic                           inflight  [32];
  logic [1:0]                     tgt_of    [32];
  logic [offload_pkg::DATA_W-1:0] exp_data  [32];
  cfg_exp_t                       cfg_q [$];
  offload_pkg::acc_req_t          sent_ext [$];
  ext_job_t                       jobs [$];

  integer      seed;
  int unsigned sent;
  int unsigned received;
  int unsigned cycle = 0;
  logic        req_pending;

  tb_clock i_clock (
    .clk_o (clk)
  );

  core_offload_complex DUT (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .core_req_i       (core_req),
    .core_req_valid_i (core_req_valid),
    .core_req_ready_o (core_req_ready),
    .core_rsp_o       (core_rsp),
    .core_rsp_valid_o (core_rsp_valid),
    .core_rsp_ready_i (core_rsp_ready),
    .ext_req_o        (ext_req),
    .ext_req_valid_o  (ext_req_valid),
    .ext_req_ready_i  (ext_req_ready),
    .ext_rsp_i        (ext_rsp),
    .ext_rsp_valid_i  (ext_rsp_valid),
    .ext_rsp_ready_o  (ext_rsp_ready)
  );

  // ----------------------------------------------------------
  // Failure reporting
  // ----------------------------------------------------------
  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped after a failed check");
  endtask

  task automatic report_mismatch(string name, logic [127:0] expected, logic [127:0] actual);
    $display("ERROR at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    stop_with_failure();
  endtask

  task automatic report_problem(string what);
    $display("At %0t: %s", $time, what);
    stop_with_failure();
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT) begin
      $display("The run timed out after %0d cycles with %0d of %0d responses", cycle,
               received, NUM_REQ);
      stop_with_failure();
    end
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  // Answer rule of the external accelerators
  function automatic logic [31:0] ext_result(offload_pkg::acc_req_t req, int unsigned t);
    return (req.arga ^ req.argb) + t;
  endfunction

  function automatic int first_job(int unsigned t);
    first_job = -1;
    for (int k = jobs.size() - 1; k >= 0; k--) begin
      if (32'(jobs[k].tgt) == t) first_job = k;
    end
  endfunction

  function automatic int oldest_for_target(int unsigned t);
    oldest_for_target = -1;
    for (int k = sent_ext.size() - 1; k >= 0; k--) begin
      if (32'(sent_ext[k].target) == t) oldest_for_target = k;
    end
  endfunction

  // Decode a config request and update the register model
  task automatic model_cfg(offload_pkg::acc_req_t req);
    logic [11:0] addr;
    logic [4:0]  dm;
    logic [6:0]  rg;
    logic [3:0]  idx;
    logic        wr;
    logic        ok;
    cfg_exp_t    e;
    wr = (req.op[6:0] == offload_pkg::CFG_OP_WRITE_IMM) ||
         (req.op[6:0] == offload_pkg::CFG_OP_WRITE);
    if (req.op[6:0] == offload_pkg::CFG_OP_READ_IMM ||
        req.op[6:0] == offload_pkg::CFG_OP_WRITE_IMM) begin
      addr = req.op[31:20];
    end else if (req.op[6:0] == offload_pkg::CFG_OP_READ ||
                 req.op[6:0] == offload_pkg::CFG_OP_WRITE) begin
      addr = req.argb[11:0];
    end else begin
      addr = '0;
    end
    dm  = addr[4:0];
    rg  = addr[11:5];
    ok  = (32'(dm) < offload_pkg::NUM_DM) && (32'(rg) < offload_pkg::NUM_REG);
    idx = 4'(32'(dm) * offload_pkg::NUM_REG + 32'(rg));
    e.wr   = wr;
    e.id   = req.id;
    e.data = '0;
    if (ok) begin
      e.data = cfg_model[idx];
      if (wr) cfg_model[idx] = req.arga;
    end
    cfg_q.push_back(e);
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  task automatic make_request();
    offload_pkg::acc_req_t req;
    logic [31:0]           r;
    logic [11:0]           addr;
    logic [6:0]            opc;
    logic [4:0]            cand;
    logic [4:0]            id;
    int unsigned           start;
    logic                  found;
    found = 1'b0;
    id    = '0;
    start = rand_word() % 31;
    for (int k = 0; k < 31; k++) begin
      cand = 5'(((start + k) % 31) + 1);
      if (!found && !inflight[cand]) begin
        found = 1'b1;
        id    = cand;
      end
    end
    if (!found) return;
    r          = rand_word();
    req.target = r[1:0];
    req.id     = id;
    req.arga   = rand_word();
    req.argb   = rand_word();
    req.op     = rand_word();
    if (32'(req.target) == offload_pkg::TARGET_CFG) begin
      r = rand_word();
      case (r[2:0])
        3'd0, 3'd1: opc = offload_pkg::CFG_OP_READ_IMM;
        3'd2, 3'd3: opc = offload_pkg::CFG_OP_WRITE_IMM;
        3'd4:       opc = offload_pkg::CFG_OP_READ;
        3'd5, 3'd6: opc = offload_pkg::CFG_OP_WRITE;
        default:    opc = 7'h33;
      endcase
      // Mostly valid words, sometimes anywhere in the 12-bit space
      if (r[6:3] != 4'd0) addr = {4'd0, r[9:7], 4'd0, r[10]};
      else addr = r[22:11];
      req.op[6:0] = opc;
      if (opc == offload_pkg::CFG_OP_READ_IMM || opc == offload_pkg::CFG_OP_WRITE_IMM) begin
        req.op[31:20] = addr;
      end else begin
        req.argb[11:0] = addr;
      end
    end
    core_req       = req;
    core_req_valid = 1'b1;
    req_pending    = 1'b1;
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    logic [1:0]  ti;
    int          k;
    r = rand_word();
    if (!req_pending) begin
      core_req_valid = 1'b0;
      if (sent < NUM_REQ && r[1:0] != 2'd0) make_request();
    end
    core_rsp_ready = (r[3:2] != 2'd0);
    for (int t = 0; t < NUM_EXT; t++) begin
      ti = 2'(t);
      r  = rand_word();
      ext_req_ready[ti] = r[0] | r[1];
      k  = first_job(t);
      if (k >= 0 && jobs[k].due <= cycle) begin
        ext_rsp_valid[ti] = 1'b1;
        ext_rsp[ti]       = jobs[k].rsp;
      end else begin
        ext_rsp_valid[ti] = 1'b0;
        ext_rsp[ti]       = '0;
      end
    end
  endtask

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  task automatic record_request(offload_pkg::acc_req_t req);
    inflight[req.id] = 1'b1;
    tgt_of[req.id]   = req.target;
    if (32'(req.target) == offload_pkg::TARGET_CFG) begin
      model_cfg(req);
    end else begin
      exp_data[req.id] = ext_result(req, 32'(req.target));
      sent_ext.push_back(req);
    end
    sent++;
  endtask

  task automatic check_ext_request(int unsigned t);
    ext_job_t job;
    int       k;
    assert (32'(ext_req.target) == t)
      else report_mismatch("ext_req_o.target", 128'(t), 128'(ext_req.target));
    k = oldest_for_target(t);
    assert (k >= 0)
      else report_problem($sformatf("External port %0d took a request never sent to it", t));
    assert (ext_req == sent_ext[k])
      else report_mismatch("ext_req_o", 128'(sent_ext[k]), 128'(ext_req));
    sent_ext.delete(k);
    job.tgt       = 2'(t);
    job.due       = cycle + 1 + (rand_word() % MAX_DELAY);
    job.rsp.id    = ext_req.id;
    job.rsp.error = 1'b0;
    job.rsp.data  = ext_result(ext_req, t);
    jobs.push_back(job);
  endtask

  task automatic check_response();
    cfg_exp_t   e;
    logic [4:0] id;
    id = core_rsp.id;
    assert (core_rsp.error == 1'b0)
      else report_mismatch("core_rsp_o.error", 128'(0), 128'(core_rsp.error));
    if (id == '0) begin
      assert (cfg_q.size() > 0 && cfg_q[0].wr)
        else report_problem("A response with id 0 came while no config write was pending");
      e = cfg_q.pop_front();
      assert (core_rsp.data == e.data)
        else report_mismatch("core_rsp_o.data", 128'(e.data), 128'(core_rsp.data));
      inflight[e.id] = 1'b0;
    end else begin
      assert (inflight[id])
        else report_problem($sformatf("A response came with id %0d, which is not in flight", id));
      if (32'(tgt_of[id]) == offload_pkg::TARGET_CFG) begin
        assert (cfg_q.size() > 0 && !cfg_q[0].wr && cfg_q[0].id == id)
          else report_problem("A config read response came out of request order");
        e = cfg_q.pop_front();
        assert (core_rsp.data == e.data)
          else report_mismatch("core_rsp_o.data", 128'(e.data), 128'(core_rsp.data));
      end else begin
        assert (core_rsp.data == exp_data[id])
          else report_mismatch("core_rsp_o.data", 128'(exp_data[id]), 128'(core_rsp.data));
      end
      inflight[id] = 1'b0;
    end
    received++;
  endtask

  // Handshakes seen here complete at the next rising edge
  task automatic observe_transfers();
    logic [1:0] ti;
    if (core_req_valid && core_req_ready) begin
      record_request(core_req);
      req_pending = 1'b0;
    end
    for (int t = 0; t < NUM_EXT; t++) begin
      ti = 2'(t);
      if (ext_req_valid[ti] && ext_req_ready[ti]) check_ext_request(t);
      if (ext_rsp_valid[ti] && ext_rsp_ready[ti]) jobs.delete(first_job(t));
    end
    if (core_rsp_valid && core_rsp_ready) check_response();
  endtask

  task automatic run_cycle();
    @(negedge clk);
    drive_inputs();
    #1;
    observe_transfers();
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    seed           = 32'h75aa02d1;
    rst_n          = 1'b1;
    core_req       = '0;
    core_req_valid = 1'b0;
    core_rsp_ready = 1'b0;
    ext_req_ready  = '0;
    ext_rsp        = '0;
    ext_rsp_valid  = '0;
    req_pending    = 1'b0;
    sent           = 0;
    received       = 0;
    for (int i = 0; i < 32; i++) begin
      inflight[i] = 1'b0;
      tgt_of[i]   = '0;
      exp_data[i] = '0;
    end
    for (int i = 0; i < NUM_WORDS; i++) begin
      cfg_model[i] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    while (received < NUM_REQ) begin
      run_cycle();
    end
    // Drain window catches any extra response
    repeat (20) run_cycle();
    assert (sent == NUM_REQ)
      else report_mismatch("requests sent", 128'(NUM_REQ), 128'(sent));
    assert (received == sent)
      else report_mismatch("responses received", 128'(sent), 128'(received));
    assert (cfg_q.size() == 0)
      else report_problem("Config responses were still expected at the end");
    assert (sent_ext.size() == 0)
      else report_problem("Some requests never reached their external target");
    assert (jobs.size() == 0)
      else report_problem("Some external responses were never taken");
    for (int i = 0; i < 32; i++) begin
      assert (!inflight[i])
        else report_problem($sformatf("Id %0d is still waiting for its response", i));
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
source/offload_pkg.sv
source/offload_spill.sv
source/offload_router.sv
source/cfg_regfile.sv
source/cfg_ctrl.sv
source/core_offload_complex.sv
tb/tb_clock.sv
tb/offload_assertions.sv
tb/offload_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the offload testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module offload_tb \
  -Mdir obj_dir -o offload_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/offload_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $status -ne 0 ] || ! grep -q "Done: no errors" "$LOG"; then
  echo "Simulation FAILED with status $status"
  exit 1
fi
echo "Simulation PASSED"
exit 0
